// ==== verilog/axi_rd_pkg.sv ====
package axi_rd_pkg;

    // incrementing burst type
    localparam logic [1:0] BURST_INCR = 2'b01;

    // log2 of bytes per beat, 8 bits gives 0
    function automatic logic [2:0] calc_arsize(input int data_width);
        logic [2:0] size;
        size = 3'd0;
        for (int i = 0; i < 8; i++) begin
            if ((8 << i) == data_width) begin
                size = 3'(i);
            end
        end
        return size;
    endfunction

endpackage

// ==== verilog/video_rd_pkg.sv ====
package video_rd_pkg;

    localparam int ADDR_WIDTH = 32;

    // axi burst length minus one
    typedef logic [7:0] burst_len_t;

    // raw view is what the command fifo stores
    typedef union packed {
        logic [$bits(burst_len_t)+ADDR_WIDTH-1:0] raw;
        struct packed {
            burst_len_t             len;
            logic [ADDR_WIDTH-1:0]  addr;
        } fields;
    } cmd_word_u;

    localparam int CMD_DEPTH       = 16;
    localparam int CMD_READY_LIMIT = 12;

    localparam int DATA_DEPTH      = 512;
    localparam int MAX_BURST_BEATS = 256;

    // one line of pixels
    localparam int LINE_DEPTH      = 1024;

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                         i_axi_clk,
    input  logic                         axi_reset_sync,
    input  logic                         i_wr_en,
    input  logic [WIDTH-1:0]             i_wr_data,
    input  logic                         i_rd_en,
    output logic [WIDTH-1:0]             o_rd_data,
    output logic                         o_rd_valid,
    output logic [$clog2(DEPTH+1)-1:0]   o_count,
    output logic                         o_empty,
    output logic                         o_overflow,
    output logic                         o_underflow
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    assign full    = (o_count == DEPTH);
    assign o_empty = (o_count == '0);
    assign wr_ok   = i_wr_en && ~full;
    assign rd_ok   = i_rd_en && ~o_empty;

    always_ff @(posedge i_axi_clk) begin
        if (axi_reset_sync) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            o_count     <= '0;
            o_rd_valid  <= 1'b0;
            o_overflow  <= 1'b0;
            o_underflow <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count;
            endcase
            o_rd_valid <= rd_ok;
            // sticky until reset
            if (i_wr_en && full) begin
                o_overflow <= 1'b1;
            end
            if (i_rd_en && o_empty) begin
                o_underflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_axi_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wr_data;
        end
        if (rd_ok) begin
            o_rd_data <= mem[rd_ptr];
        end else begin
            o_rd_data <= '0;
        end
    end

endmodule

// ==== verilog/axi_rd_issuer.sv ====
`timescale 1ns/1ps

module axi_rd_issuer #(
    parameter int AXI_DATA_WIDTH = 128
) (
    input  logic                                            i_axi_clk,
    input  logic                                            axi_reset_sync,
    input  logic                                            i_cmd_empty,
    input  video_rd_pkg::cmd_word_u                         i_cmd_word,
    input  logic [$clog2(video_rd_pkg::DATA_DEPTH+1)-1:0]   i_data_count,
    input  logic                                            i_m_axi_arready,
    input  logic                                            i_m_axi_rvalid,
    input  logic                                            i_m_axi_rlast,
    output logic                                            o_cmd_pop,
    output logic                                            o_m_axi_arvalid,
    output logic [video_rd_pkg::ADDR_WIDTH-1:0]             o_m_axi_araddr,
    output video_rd_pkg::burst_len_t                        o_m_axi_arlen,
    output logic [2:0]                                      o_m_axi_arsize,
    output logic [1:0]                                      o_m_axi_arburst
);

    localparam logic [3:0] ST_IDLE = 4'b0001;
    localparam logic [3:0] ST_PREP = 4'b0010;
    localparam logic [3:0] ST_DATA = 4'b0100;
    localparam logic [3:0] ST_END  = 4'b1000;

    // room for the longest burst
    localparam int ADMIT_LIMIT = video_rd_pkg::DATA_DEPTH - video_rd_pkg::MAX_BURST_BEATS;

    logic [3:0] state;
    logic [3:0] state_next;
    logic       start;

    assign start = ~i_cmd_empty && (i_data_count <= ADMIT_LIMIT);

    // pop on leaving idle so the word is on the fifo output during prepare
    assign o_cmd_pop = (state == ST_IDLE) && start;

    assign o_m_axi_arsize  = axi_rd_pkg::calc_arsize(AXI_DATA_WIDTH);
    assign o_m_axi_arburst = axi_rd_pkg::BURST_INCR;

    always_comb begin
        case (state)
            ST_IDLE: state_next = start ? ST_PREP : ST_IDLE;
            ST_PREP: state_next = ST_DATA;
            ST_DATA: state_next = (i_m_axi_rvalid && i_m_axi_rlast) ? ST_END : ST_DATA;
            ST_END:  state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_axi_clk) begin
        if (axi_reset_sync) begin
            state           <= ST_IDLE;
            o_m_axi_arvalid <= 1'b0;
        end else begin
            state <= state_next;
            if (o_m_axi_arvalid && i_m_axi_arready) begin
                o_m_axi_arvalid <= 1'b0;
            end else if (state == ST_PREP) begin
                o_m_axi_arvalid <= 1'b1;
            end
        end
    end

    // address and length held until the next prepare
    always_ff @(posedge i_axi_clk) begin
        if (state == ST_PREP) begin
            o_m_axi_araddr <= i_cmd_word.fields.addr;
            o_m_axi_arlen  <= i_cmd_word.fields.len;
        end
    end

endmodule

// ==== verilog/beat_unpacker.sv ====
`timescale 1ns/1ps

module beat_unpacker #(
    parameter int AXI_DATA_WIDTH = 128,
    parameter int PIXEL_WIDTH    = 16
) (
    input  logic                                            i_axi_clk,
    input  logic                                            axi_reset_sync,
    input  logic                                            i_data_empty,
    input  logic [AXI_DATA_WIDTH:0]                         i_data_word,
    input  logic [$clog2(video_rd_pkg::LINE_DEPTH+1)-1:0]   i_line_count,
    input  logic [15:0]                                     i_video_width,
    output logic                                            o_data_pop,
    output logic                                            o_pixel_wr,
    output logic [PIXEL_WIDTH:0]                            o_pixel_word
);

    localparam int PIX_PER_BEAT = AXI_DATA_WIDTH / PIXEL_WIDTH;
    localparam int SUB_W        = $clog2(PIX_PER_BEAT);
    // new beat plus pixels still in the shifter and pipeline
    localparam int LINE_LIMIT   = video_rd_pkg::LINE_DEPTH - 2 * PIX_PER_BEAT;

    logic                       load;
    logic                       shifting;
    logic [SUB_W-1:0]           sub_cnt;
    logic                       sub_end;
    logic                       slot_free;
    logic [AXI_DATA_WIDTH-1:0]  shift_reg;
    logic                       beat_last;
    logic                       pix_valid;
    logic                       pix_line_end;
    logic [PIXEL_WIDTH-1:0]     pix_data;
    logic [15:0]                line_cnt;
    logic                       pix_mask;
    logic                       pix_last;

    assign sub_end = (sub_cnt == SUB_W'(PIX_PER_BEAT - 1));

    // next word may be requested two pixels before the shifter runs dry
    assign slot_free  = ~load && (~shifting || sub_cnt >= SUB_W'(PIX_PER_BEAT - 2));
    assign o_data_pop = slot_free && ~i_data_empty && (i_line_count <= LINE_LIMIT);

    assign pix_mask = (line_cnt >= i_video_width);
    assign pix_last = (line_cnt == i_video_width - 16'd1);

    always_ff @(posedge i_axi_clk) begin
        if (axi_reset_sync) begin
            load     <= 1'b0;
            shifting <= 1'b0;
            sub_cnt  <= '0;
        end else begin
            load <= o_data_pop;
            if (load) begin
                shifting <= 1'b1;
                sub_cnt  <= '0;
            end else if (shifting) begin
                if (sub_end) begin
                    shifting <= 1'b0;
                    sub_cnt  <= '0;
                end else begin
                    sub_cnt <= sub_cnt + 1'b1;
                end
            end
        end
    end

    // lowest pixel leaves first
    always_ff @(posedge i_axi_clk) begin
        if (load) begin
            shift_reg <= i_data_word[AXI_DATA_WIDTH-1:0];
            beat_last <= i_data_word[AXI_DATA_WIDTH];
        end else if (shifting) begin
            shift_reg <= shift_reg >> PIXEL_WIDTH;
        end
        pix_data     <= shift_reg[PIXEL_WIDTH-1:0];
        o_pixel_word <= {pix_last, pix_data};
    end

    always_ff @(posedge i_axi_clk) begin
        if (axi_reset_sync) begin
            pix_valid    <= 1'b0;
            pix_line_end <= 1'b0;
            line_cnt     <= '0;
            o_pixel_wr   <= 1'b0;
        end else begin
            pix_valid    <= shifting;
            pix_line_end <= shifting && sub_end && beat_last;
            // line restarts after the final pixel of the rlast beat
            if (pix_valid && pix_line_end) begin
                line_cnt <= '0;
            end else if (pix_valid) begin
                line_cnt <= line_cnt + 16'd1;
            end
            o_pixel_wr <= pix_valid && ~pix_mask;
        end
    end

endmodule

// ==== verilog/video_rd_buffer.sv ====
`timescale 1ns/1ps

module video_rd_buffer #(
    parameter int AXI_DATA_WIDTH = 128,
    parameter int PIXEL_WIDTH    = 16
) (
    input  logic                                i_axi_clk,
    input  logic                                axi_reset_sync,
    input  logic                                i_req_en,
    output logic                                o_req_ready,
    input  video_rd_pkg::burst_len_t            i_req_len,
    input  logic [video_rd_pkg::ADDR_WIDTH-1:0] i_req_addr,
    input  logic [15:0]                         i_video_width,
    input  logic                                i_line_rden,
    output logic                                o_m_axi_arvalid,
    input  logic                                i_m_axi_arready,
    output logic [video_rd_pkg::ADDR_WIDTH-1:0] o_m_axi_araddr,
    output video_rd_pkg::burst_len_t            o_m_axi_arlen,
    output logic [2:0]                          o_m_axi_arsize,
    output logic [1:0]                          o_m_axi_arburst,
    input  logic                                i_m_axi_rvalid,
    output logic                                o_m_axi_rready,
    input  logic [AXI_DATA_WIDTH-1:0]           i_m_axi_rdata,
    input  logic                                i_m_axi_rlast,
    output logic [PIXEL_WIDTH-1:0]              o_video_data,
    output logic                                o_video_last,
    output logic                                o_video_valid,
    output logic                                o_cmd_fifo_err,
    output logic                                o_data_fifo_err,
    output logic                                o_line_buf_err,
    output logic                                o_line_empty_err
);

    localparam int CMD_CW  = $clog2(video_rd_pkg::CMD_DEPTH + 1);
    localparam int DATA_CW = $clog2(video_rd_pkg::DATA_DEPTH + 1);
    localparam int LINE_CW = $clog2(video_rd_pkg::LINE_DEPTH + 1);

    video_rd_pkg::cmd_word_u    cmd_rd_word;
    logic [CMD_CW-1:0]          cmd_count;
    logic                       cmd_empty;
    logic                       cmd_pop;
    logic [AXI_DATA_WIDTH:0]    data_rd_word;
    logic [DATA_CW-1:0]         data_count;
    logic                       data_empty;
    logic                       data_pop;
    logic [PIXEL_WIDTH:0]       pixel_word;
    logic                       pixel_wr;
    logic [PIXEL_WIDTH:0]       line_rd_word;
    logic [LINE_CW-1:0]         line_count;

    // no requests taken while in reset
    assign o_req_ready    = ~axi_reset_sync && (cmd_count < video_rd_pkg::CMD_READY_LIMIT);
    assign o_m_axi_rready = 1'b1;

    assign o_video_data = line_rd_word[PIXEL_WIDTH-1:0];
    assign o_video_last = line_rd_word[PIXEL_WIDTH];

    // len in the upper byte above the address
    sync_fifo #(
        .WIDTH ($bits(video_rd_pkg::cmd_word_u)),
        .DEPTH (video_rd_pkg::CMD_DEPTH)
    ) i_cmd_fifo (
        .i_axi_clk      (i_axi_clk),
        .axi_reset_sync (axi_reset_sync),
        .i_wr_en        (i_req_en && o_req_ready),
        .i_wr_data      ({i_req_len, i_req_addr}),
        .i_rd_en        (cmd_pop),
        .o_rd_data      (cmd_rd_word.raw),
        .o_rd_valid     (),
        .o_count        (cmd_count),
        .o_empty        (cmd_empty),
        .o_overflow     (o_cmd_fifo_err),
        .o_underflow    ()
    );

    // beat with rlast on top
    sync_fifo #(
        .WIDTH (AXI_DATA_WIDTH + 1),
        .DEPTH (video_rd_pkg::DATA_DEPTH)
    ) i_data_fifo (
        .i_axi_clk      (i_axi_clk),
        .axi_reset_sync (axi_reset_sync),
        .i_wr_en        (i_m_axi_rvalid),
        .i_wr_data      ({i_m_axi_rlast, i_m_axi_rdata}),
        .i_rd_en        (data_pop),
        .o_rd_data      (data_rd_word),
        .o_rd_valid     (),
        .o_count        (data_count),
        .o_empty        (data_empty),
        .o_overflow     (o_data_fifo_err),
        .o_underflow    ()
    );

    sync_fifo #(
        .WIDTH (PIXEL_WIDTH + 1),
        .DEPTH (video_rd_pkg::LINE_DEPTH)
    ) i_line_fifo (
        .i_axi_clk      (i_axi_clk),
        .axi_reset_sync (axi_reset_sync),
        .i_wr_en        (pixel_wr),
        .i_wr_data      (pixel_word),
        .i_rd_en        (i_line_rden),
        .o_rd_data      (line_rd_word),
        .o_rd_valid     (o_video_valid),
        .o_count        (line_count),
        .o_empty        (),
        .o_overflow     (o_line_buf_err),
        .o_underflow    (o_line_empty_err)
    );

    axi_rd_issuer #(
        .AXI_DATA_WIDTH (AXI_DATA_WIDTH)
    ) i_axi_rd_issuer (
        .i_axi_clk       (i_axi_clk),
        .axi_reset_sync  (axi_reset_sync),
        .i_cmd_empty     (cmd_empty),
        .i_cmd_word      (cmd_rd_word),
        .i_data_count    (data_count),
        .i_m_axi_arready (i_m_axi_arready),
        .i_m_axi_rvalid  (i_m_axi_rvalid),
        .i_m_axi_rlast   (i_m_axi_rlast),
        .o_cmd_pop       (cmd_pop),
        .o_m_axi_arvalid (o_m_axi_arvalid),
        .o_m_axi_araddr  (o_m_axi_araddr),
        .o_m_axi_arlen   (o_m_axi_arlen),
        .o_m_axi_arsize  (o_m_axi_arsize),
        .o_m_axi_arburst (o_m_axi_arburst)
    );

    beat_unpacker #(
        .AXI_DATA_WIDTH (AXI_DATA_WIDTH),
        .PIXEL_WIDTH    (PIXEL_WIDTH)
    ) i_beat_unpacker (
        .i_axi_clk      (i_axi_clk),
        .axi_reset_sync (axi_reset_sync),
        .i_data_empty   (data_empty),
        .i_data_word    (data_rd_word),
        .i_line_count   (line_count),
        .i_video_width  (i_video_width),
        .o_data_pop     (data_pop),
        .o_pixel_wr     (pixel_wr),
        .o_pixel_word   (pixel_word)
    );

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
    parameter int RESET_CYCLES = 4
) (
    output logic o_axi_clk,
    output logic o_reset
);

    // 4 ns period
    initial begin
        o_axi_clk = 1'b0;
        forever #2 o_axi_clk = ~o_axi_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_axi_clk);
        @(negedge o_axi_clk);
        o_reset = 1'b0;
    end

endmodule

// ==== tb/tb_video_rd_buffer.sv ====
`timescale 1ns/1ps

module tb_video_rd_buffer;

    localparam int AXI_DATA_WIDTH = 128;
    localparam int PIXEL_WIDTH    = 16;
    localparam int PIX_PER_BEAT   = AXI_DATA_WIDTH / PIXEL_WIDTH;
    localparam int MAX_CMDS       = 64;
    // 16 bytes per beat
    localparam logic [2:0] ARSIZE_EXP = 3'd4;
    localparam logic [1:0] INCR_EXP   = 2'b01;

    logic                       axi_clk;
    logic                       axi_reset_sync;
    logic                       i_req_en;
    logic                       o_req_ready;
    logic [7:0]                 i_req_len;
    logic [31:0]                i_req_addr;
    logic [15:0]                i_video_width;
    logic                       i_line_rden;
    logic                       o_m_axi_arvalid;
    logic                       i_m_axi_arready;
    logic [31:0]                o_m_axi_araddr;
    logic [7:0]                 o_m_axi_arlen;
    logic [2:0]                 o_m_axi_arsize;
    logic [1:0]                 o_m_axi_arburst;
    logic                       i_m_axi_rvalid;
    logic                       o_m_axi_rready;
    logic [AXI_DATA_WIDTH-1:0]  i_m_axi_rdata;
    logic                       i_m_axi_rlast;
    logic [PIXEL_WIDTH-1:0]     o_video_data;
    logic                       o_video_last;
    logic                       o_video_valid;
    logic                       o_cmd_fifo_err;
    logic                       o_data_fifo_err;
    logic                       o_line_buf_err;
    logic                       o_line_empty_err;

    logic [31:0]                stim [0:3*MAX_CMDS-1];
    int                         num_cmds;
    int                         cycle_count;
    int                         cycle_limit;
    logic [31:0]                rng_state;

    clk_gen i_clk_gen (
        .o_axi_clk (axi_clk),
        .o_reset   (axi_reset_sync)
    );

    video_rd_buffer #(
        .AXI_DATA_WIDTH (AXI_DATA_WIDTH),
        .PIXEL_WIDTH    (PIXEL_WIDTH)
    ) i_video_rd_buffer (
        .i_axi_clk        (axi_clk),
        .axi_reset_sync   (axi_reset_sync),
        .i_req_en         (i_req_en),
        .o_req_ready      (o_req_ready),
        .i_req_len        (i_req_len),
        .i_req_addr       (i_req_addr),
        .i_video_width    (i_video_width),
        .i_line_rden      (i_line_rden),
        .o_m_axi_arvalid  (o_m_axi_arvalid),
        .i_m_axi_arready  (i_m_axi_arready),
        .o_m_axi_araddr   (o_m_axi_araddr),
        .o_m_axi_arlen    (o_m_axi_arlen),
        .o_m_axi_arsize   (o_m_axi_arsize),
        .o_m_axi_arburst  (o_m_axi_arburst),
        .i_m_axi_rvalid   (i_m_axi_rvalid),
        .o_m_axi_rready   (o_m_axi_rready),
        .i_m_axi_rdata    (i_m_axi_rdata),
        .i_m_axi_rlast    (i_m_axi_rlast),
        .o_video_data     (o_video_data),
        .o_video_last     (o_video_last),
        .o_video_valid    (o_video_valid),
        .o_cmd_fifo_err   (o_cmd_fifo_err),
        .o_data_fifo_err  (o_data_fifo_err),
        .o_line_buf_err   (o_line_buf_err),
        .o_line_empty_err (o_line_empty_err)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(input int unsigned range, output int unsigned value);
        rng_state = xorshift32(rng_state);
        value = rng_state % range;
    endtask

    // slave memory model for pixel j of beat k
    function automatic logic [AXI_DATA_WIDTH-1:0] make_beat(input logic [31:0] addr,
                                                            input int k);
        logic [AXI_DATA_WIDTH-1:0] beat;
        logic [31:0]               v;
        int                        j;
        beat = '0;
        for (j = 0; j < PIX_PER_BEAT; j++) begin
            v = addr + 32'(k * 16) + 32'(j * 2);
            beat[j*PIXEL_WIDTH +: PIXEL_WIDTH] = v[PIXEL_WIDTH-1:0];
        end
        return beat;
    endfunction

    // p-th pixel of the line at two bytes per pixel
    function automatic logic [15:0] expected_pixel(input logic [31:0] addr, input int p);
        logic [31:0] v;
        v = addr + 32'(2 * p);
        return v[15:0];
    endfunction

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_no_errors(input logic [31:0] empty_exp);
        check_value("o_cmd_fifo_err", o_cmd_fifo_err, 0);
        check_value("o_data_fifo_err", o_data_fifo_err, 0);
        check_value("o_line_buf_err", o_line_buf_err, 0);
        check_value("o_line_empty_err", o_line_empty_err, empty_exp);
    endtask

    task automatic run_command(input logic [15:0] width, input logic [7:0] len,
                               input logic [31:0] addr);
        int unsigned delay;
        int unsigned gap;
        int          beats;
        int          n;
        int          k;
        int          i;
        beats = int'(len) + 1;
        n = (int'(width) < beats * PIX_PER_BEAT) ? int'(width) : beats * PIX_PER_BEAT;
        while (!o_req_ready) begin
            @(negedge axi_clk);
        end
        i_video_width = width;
        i_req_len     = len;
        i_req_addr    = addr;
        i_req_en      = 1'b1;
        @(negedge axi_clk);
        i_req_en = 1'b0;

        // address channel with random arready delay
        while (!o_m_axi_arvalid) begin
            @(negedge axi_clk);
        end
        check_value("o_m_axi_araddr", o_m_axi_araddr, addr);
        check_value("o_m_axi_arlen", o_m_axi_arlen, len);
        check_value("o_m_axi_arsize", o_m_axi_arsize, ARSIZE_EXP);
        check_value("o_m_axi_arburst", o_m_axi_arburst, INCR_EXP);
        draw_random(6, delay);
        repeat (delay) begin
            @(negedge axi_clk);
            check_value("o_m_axi_arvalid", o_m_axi_arvalid, 1);
            check_value("o_m_axi_araddr", o_m_axi_araddr, addr);
        end
        i_m_axi_arready = 1'b1;
        @(negedge axi_clk);
        i_m_axi_arready = 1'b0;
        check_value("o_m_axi_arvalid", o_m_axi_arvalid, 0);

        for (k = 0; k < beats; k++) begin
            draw_random(4, gap);
            repeat (gap) @(negedge axi_clk);
            i_m_axi_rvalid = 1'b1;
            i_m_axi_rdata  = make_beat(addr, k);
            i_m_axi_rlast  = (k == beats - 1);
            @(negedge axi_clk);
            i_m_axi_rvalid = 1'b0;
            i_m_axi_rlast  = 1'b0;
        end

        // unpacker drains 8 pixels per beat
        repeat (8 * beats + 8) @(negedge axi_clk);

        for (i = 0; i <= n; i++) begin
            if (i > 0) begin
                check_value("o_video_valid", o_video_valid, 1);
                check_value("o_video_data", o_video_data, expected_pixel(addr, i - 1));
                check_value("o_video_last", o_video_last, (i - 1) == int'(width) - 1);
            end
            i_line_rden = (i < n);
            @(negedge axi_clk);
        end
        check_value("o_video_valid", o_video_valid, 0);
        check_value("o_video_data", o_video_data, 0);
        check_value("o_video_last", o_video_last, 0);
        check_no_errors(0);
    endtask

    always @(posedge axi_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    initial begin
        int c;
        i_req_en        = 1'b0;
        i_req_len       = '0;
        i_req_addr      = '0;
        i_video_width   = '0;
        i_line_rden     = 1'b0;
        i_m_axi_arready = 1'b0;
        i_m_axi_rvalid  = 1'b0;
        i_m_axi_rdata   = '0;
        i_m_axi_rlast   = 1'b0;
        rng_state       = 32'd71;
        cycle_count     = 0;
        for (c = 0; c < 3 * MAX_CMDS; c++) begin
            stim[c] = 32'hffff_ffff;
        end
        $readmemh("tb/video_rd_stim.txt", stim);
        num_cmds    = 0;
        cycle_limit = 500;
        while (num_cmds < MAX_CMDS && stim[3*num_cmds] != 32'hffff_ffff) begin
            cycle_limit = cycle_limit + 20 * (int'(stim[3*num_cmds+1][7:0]) + 1) * 8;
            num_cmds = num_cmds + 1;
        end
        assert (num_cmds > 0) else begin
            $display("no commands found in tb/video_rd_stim.txt");
            stop_run();
        end

        // still inside the reset window
        @(posedge axi_clk);
        @(negedge axi_clk);
        check_value("o_req_ready", o_req_ready, 0);
        check_value("o_m_axi_arvalid", o_m_axi_arvalid, 0);

        wait (!axi_reset_sync);
        @(negedge axi_clk);
        check_value("o_m_axi_arvalid", o_m_axi_arvalid, 0);
        check_value("o_video_valid", o_video_valid, 0);
        check_value("o_video_last", o_video_last, 0);
        check_no_errors(0);
        check_value("o_req_ready", o_req_ready, 1);
        check_value("o_m_axi_rready", o_m_axi_rready, 1);

        for (c = 0; c < num_cmds; c++) begin
            run_command(stim[3*c][15:0], stim[3*c+1][7:0], stim[3*c+2]);
        end

        // one read too many on a drained buffer
        i_line_rden = 1'b1;
        @(negedge axi_clk);
        i_line_rden = 1'b0;
        check_value("o_video_valid", o_video_valid, 0);
        check_no_errors(1);
        repeat (5) @(negedge axi_clk);
        check_no_errors(1);

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== tb/video_rd_stim.txt ====
// columns: line width, burst length minus one, start address (all hex)
// one command per line
0040 07 00001000
0020 07 00002000
0100 07 00003000
0001 00 00004000
0008 00 00004010
0005 00 00004020
000c 01 00004100
0010 01 00004200
0018 01 000042f0
0080 0f 00005000
0064 0f 00006000
00c8 1f 00007000
0100 1f 00008000
0200 1f 00009000
0190 3f 0000a000
0200 3f 0000b000
0003 02 0000c006
0017 02 0000c106
0018 02 0000c206
001f 03 0000fffa
03e8 7f 00010000
0007 ff 00030000

// ==== compile.f ====
verilog/axi_rd_pkg.sv
verilog/video_rd_pkg.sv
verilog/sync_fifo.sv
verilog/axi_rd_issuer.sv
verilog/beat_unpacker.sv
verilog/video_rd_buffer.sv
tb/clk_gen.sv
tb/tb_video_rd_buffer.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_video_rd_buffer
SOURCES := $(wildcard verilog/*.sv tb/*.sv)

.PHONY: all run clean

all: run

$(SIM): compile.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_video_rd_buffer -f compile.f

sim.log: $(SIM) tb/video_rd_stim.txt
	./$(SIM) > sim.log 2>&1 || true

run: sim.log
	@cat sim.log
	@! grep -q "Regression failed" sim.log
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
